// ==== tb.f ====
+incdir+design
design/zint_pkg.sv
design/zint_bus_decode.sv
design/zint_pending.sv
design/zint_vector.sv
design/zint_top.sv
testbench/zint_tb_asserts.sv
testbench/zint_tb.sv

// ==== Makefile ====
# Verilator build and run of the interrupt controller testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build folder and $(LOG)"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module zint_tb -f tb.f -Mdir obj_dir -o zint_sim
	./obj_dir/zint_sim 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "simulation reported a failure"; \
		exit 1; \
	fi
	@if ! grep -q "Test passed" $(LOG); then \
		echo "simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// ==== testbench/zint_tb.sv ====
`include "zint_settings.svh"

module zint_tb;

	timeunit 1ns;
	timeprecision 1ps;

	typedef enum
	{
		OP_WR,   // arg holds {addr, data}
		OP_FRM,
		OP_LIN,
		OP_DMA,
		OP_VDOS, // arg[0] is the level
		OP_ACK,  // arg is the number of cycles intack stays high
		OP_WAIT  // arg is the number of cycles
	} op_e;

	typedef struct
	{
		op_e                 op;
		logic [15:0]         arg;
		logic                exp_int_n;
		zint_pkg::im2_vect_t exp_vect;
	} row_t;

	logic                clk;
	logic                int_start_lin;
	logic                frame_start;
	logic                line_start;
	logic                dma_done;
	logic                vdos;
	logic                intack;
	logic                io_wr;
	logic [7:0]          io_addr;
	logic [7:0]          io_data;
	logic                int_n;
	zint_pkg::im2_vect_t im2vect;

	row_t                rows[$];
	bit                  table_ready;
	logic [7:0]          rnd_frm; // random bytes for the vector registers
	logic [7:0]          rnd_lin;
	logic [7:0]          rnd_dma;
	zint_pkg::im2_vect_t vf;
	zint_pkg::im2_vect_t vl;
	zint_pkg::im2_vect_t vd;

	zint_top zint_top_i
	(
		.clk           (clk),
		.int_start_lin (int_start_lin),
		.frame_start   (frame_start),
		.line_start    (line_start),
		.dma_done      (dma_done),
		.vdos          (vdos),
		.intack        (intack),
		.io_wr         (io_wr),
		.io_addr       (io_addr),
		.io_data       (io_data),
		.int_n         (int_n),
		.im2vect       (im2vect)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "run aborted");
	endtask

	task automatic check_int_n(input logic got, input logic exp, input int row);
		if (got !== exp)
			stop_with_failure($sformatf("Error: int_n is %h, expected %h (row %0d)", got, exp, row));
	endtask

	task automatic check_vect(input zint_pkg::im2_vect_t got, input zint_pkg::im2_vect_t exp,
		input int row);
		if (got !== exp)
			stop_with_failure($sformatf("Error: im2vect is %h, expected %h (row %0d)",
				got, exp, row));
	endtask

	task automatic add_row(input op_e op, input logic [15:0] arg, input logic exp_int_n,
		input zint_pkg::im2_vect_t exp_vect);
		row_t r;
		r.op = op;
		r.arg = arg;
		r.exp_int_n = exp_int_n;
		r.exp_vect = exp_vect;
		rows.push_back(r);
	endtask

	task automatic build_table();
		// expected vectors: source nibble, programmed bits, bit 0 set
		vf = {4'hF, rnd_frm[2:0], 1'b1};
		vl = {4'hE, rnd_lin[2:0], 1'b1};
		vd = {4'hD, rnd_dma[2:0], 1'b1};

		add_row(OP_WAIT, 16'd1, 1'b1, 8'hF1); // reset state
		add_row(OP_LIN, 16'd0, 1'b1, 8'hF1); // line and dma still disabled
		add_row(OP_DMA, 16'd0, 1'b1, 8'hF1);
		add_row(OP_WR, {`ZINT_ADDR_VFRM, rnd_frm}, 1'b1, vf);
		add_row(OP_WR, {`ZINT_ADDR_VLIN, rnd_lin}, 1'b1, vf);
		add_row(OP_WR, {`ZINT_ADDR_VDMA, rnd_dma}, 1'b1, vf);

		// all three pending, served by priority
		add_row(OP_WR, {`ZINT_ADDR_MASK, 8'h07}, 1'b1, vf);
		add_row(OP_DMA, 16'd0, 1'b0, vf);
		add_row(OP_LIN, 16'd0, 1'b0, vf);
		add_row(OP_FRM, 16'd0, 1'b0, vf);
		add_row(OP_ACK, 16'd1, 1'b0, vf);
		add_row(OP_ACK, 16'd1, 1'b0, vl);
		add_row(OP_ACK, 16'd1, 1'b1, vd);

		// long intack counts once
		add_row(OP_LIN, 16'd0, 1'b0, vd);
		add_row(OP_DMA, 16'd0, 1'b0, vd);
		add_row(OP_ACK, 16'd4, 1'b0, vl);
		add_row(OP_ACK, 16'd1, 1'b1, vd);
		add_row(OP_ACK, 16'd1, 1'b1, vd); // nothing pending, vector kept

		// mask cleared under a pending frame, flag drops one edge later
		add_row(OP_FRM, 16'd0, 1'b0, vd);
		add_row(OP_WR, {`ZINT_ADDR_MASK, 8'h06}, 1'b0, vd);
		add_row(OP_WAIT, 16'd1, 1'b1, vd);
		add_row(OP_FRM, 16'd0, 1'b1, vd);
		add_row(OP_WR, {`ZINT_ADDR_MASK, 8'h07}, 1'b1, vd);

		// vdos
		add_row(OP_LIN, 16'd0, 1'b0, vd);
		add_row(OP_ACK, 16'd1, 1'b1, vl);
		add_row(OP_VDOS, 16'd1, 1'b1, vl);
		add_row(OP_FRM, 16'd0, 1'b1, vl); // lost
		add_row(OP_LIN, 16'd0, 1'b1, vl); // lost
		add_row(OP_DMA, 16'd0, 1'b1, vl); // held back
		add_row(OP_VDOS, 16'd0, 1'b0, vl);
		add_row(OP_ACK, 16'd1, 1'b1, vd);

		// frame expiry without acknowledge
		add_row(OP_FRM, 16'd0, 1'b0, vd);
		add_row(OP_WAIT, 16'(`ZINT_FRM_LEN - 1), 1'b0, vd);
		add_row(OP_WAIT, 16'd1, 1'b1, vd);
		add_row(OP_ACK, 16'd1, 1'b1, vd);

		// second frame strobe restarts the count
		add_row(OP_FRM, 16'd0, 1'b0, vd);
		add_row(OP_WAIT, 16'd16, 1'b0, vd);
		add_row(OP_FRM, 16'd0, 1'b0, vd);
		add_row(OP_WAIT, 16'd16, 1'b0, vd);
		add_row(OP_WAIT, 16'(`ZINT_FRM_LEN - 17), 1'b0, vd);
		add_row(OP_WAIT, 16'd1, 1'b1, vd);
	endtask

	// drives one row on falling edges, returns one cycle after the last sample
	task automatic apply_row(input row_t r);
		case (r.op)
			OP_WR:
			begin
				io_wr = 1'b1;
				io_addr = r.arg[15:8];
				io_data = r.arg[7:0];
				@(negedge clk);
			end
			OP_FRM:
			begin
				frame_start = 1'b1;
				@(negedge clk);
			end
			OP_LIN:
			begin
				line_start = 1'b1;
				@(negedge clk);
			end
			OP_DMA:
			begin
				dma_done = 1'b1;
				@(negedge clk);
			end
			OP_VDOS:
			begin
				vdos = r.arg[0];
				@(negedge clk);
			end
			OP_ACK:
			begin
				intack = 1'b1;
				repeat (r.arg) @(negedge clk);
				intack = 1'b0; // low across one edge before the next ack
				@(negedge clk);
			end
			default:
				repeat (r.arg) @(negedge clk);
		endcase
	endtask

	task automatic release_pulses();
		io_wr = 1'b0;
		frame_start = 1'b0;
		line_start = 1'b0;
		dma_done = 1'b0;
	endtask

	initial
	begin
		int_start_lin = 1'b1;
		frame_start = 1'b0;
		line_start = 1'b0;
		dma_done = 1'b0;
		vdos = 1'b0;
		intack = 1'b0;
		io_wr = 1'b0;
		io_addr = 8'h00;
		io_data = 8'h00;
		table_ready = 1'b0;
		void'($urandom(94626));
		rnd_frm = 8'($urandom);
		rnd_lin = 8'($urandom);
		rnd_dma = 8'($urandom);
		build_table();
		table_ready = 1'b1;
		repeat (4) @(negedge clk);
		int_start_lin = 1'b0;
		foreach (rows[i])
		begin
			apply_row(rows[i]);
			check_int_n(int_n, rows[i].exp_int_n, i);
			check_vect(im2vect, rows[i].exp_vect, i);
			release_pulses();
		end
		$display("Test passed");
		$finish;
	end

	// generous bound: 64 cycles per row plus the reset
	initial
	begin
		int limit_ns;
		wait (table_ready);
		limit_ns = (rows.size() + 4) * 64 * 8;
		#(limit_ns);
		stop_with_failure("simulation timed out");
	end

endmodule

// ==== testbench/zint_tb_asserts.sv ====
module zint_tb_asserts
(
	input logic                clk,
	input logic                int_start_lin,
	input logic                ack,
	input logic                io_wr,
	input logic                pend_frm,
	input logic                pend_lin,
	input logic                pend_dma,
	input zint_pkg::int_src_e  top_src,
	input logic                int_n,
	input zint_pkg::im2_vect_t im2vect
);

	timeunit 1ns;
	timeprecision 1ps;

	// IM2 vectors are always odd
	bit0_set: assert property (@(posedge clk) disable iff (int_start_lin) im2vect[0])
		else $error("im2vect bit 0 is low");

	// no request without a flag behind it
	int_has_source: assert property (@(posedge clk) disable iff (int_start_lin)
		!int_n |-> (pend_frm || pend_lin || pend_dma))
		else $error("int_n low with no pending flag");

	// empty acknowledge, vector must not move (a register write could)
	empty_ack_keeps: assert property (@(posedge clk) disable iff (int_start_lin)
		(ack && (top_src == zint_pkg::SRC_NONE) && !io_wr) |=> $stable(im2vect))
		else $error("im2vect changed on an acknowledge with nothing pending");

endmodule

bind zint_top zint_tb_asserts zint_tb_asserts_i
(
	.clk           (clk),
	.int_start_lin (int_start_lin),
	.ack           (ack),
	.io_wr         (io_wr),
	.pend_frm      (pend_frm),
	.pend_lin      (pend_lin),
	.pend_dma      (pend_dma),
	.top_src       (top_src),
	.int_n         (int_n),
	.im2vect       (im2vect)
);

// ==== design/zint_top.sv ====
module zint_top
(
	input  logic                clk,
	input  logic                int_start_lin,
	input  logic                frame_start,
	input  logic                line_start,
	input  logic                dma_done,
	input  logic                vdos,
	input  logic                intack,
	input  logic                io_wr,
	input  logic [7:0]          io_addr,
	input  logic [7:0]          io_data,
	output logic                int_n,
	output zint_pkg::im2_vect_t im2vect
);

	logic                ack;
	logic [2:0]          intmask;
	zint_pkg::vect_low_t im2v_frm;
	zint_pkg::vect_low_t im2v_lin;
	zint_pkg::vect_low_t im2v_dma;
	logic                pend_frm;
	logic                pend_lin;
	logic                pend_dma;
	zint_pkg::int_src_e  top_src;

	// cpu side registers and ack edge
	zint_bus_decode zint_bus_decode_i
	(
		.clk           (clk),
		.int_start_lin (int_start_lin),
		.intack        (intack),
		.io_wr         (io_wr),
		.io_addr       (io_addr),
		.io_data       (io_data),
		.ack           (ack),
		.intmask       (intmask),
		.im2v_frm      (im2v_frm),
		.im2v_lin      (im2v_lin),
		.im2v_dma      (im2v_dma)
	);

	zint_pending zint_pending_i
	(
		.clk           (clk),
		.int_start_lin (int_start_lin),
		.frame_start   (frame_start),
		.line_start    (line_start),
		.dma_done      (dma_done),
		.vdos          (vdos),
		.ack           (ack),
		.intmask       (intmask),
		.pend_frm      (pend_frm),
		.pend_lin      (pend_lin),
		.pend_dma      (pend_dma),
		.top_src       (top_src)
	);

	zint_vector zint_vector_i
	(
		.clk           (clk),
		.int_start_lin (int_start_lin),
		.ack           (ack),
		.vdos          (vdos),
		.pend_frm      (pend_frm),
		.pend_lin      (pend_lin),
		.pend_dma      (pend_dma),
		.top_src       (top_src),
		.im2v_frm      (im2v_frm),
		.im2v_lin      (im2v_lin),
		.im2v_dma      (im2v_dma),
		.int_n         (int_n),
		.im2vect       (im2vect)
	);

endmodule

// ==== design/zint_vector.sv ====
module zint_vector
(
	input  logic                clk,
	input  logic                int_start_lin,
	input  logic                ack,
	input  logic                vdos,
	input  logic                pend_frm,
	input  logic                pend_lin,
	input  logic                pend_dma,
	input  zint_pkg::int_src_e  top_src,
	input  zint_pkg::vect_low_t im2v_frm,
	input  zint_pkg::vect_low_t im2v_lin,
	input  zint_pkg::vect_low_t im2v_dma,
	output logic                int_n,
	output zint_pkg::im2_vect_t im2vect
);

	zint_pkg::int_src_e src_sel; // source of the last acknowledge

	// dma request stays invisible to the cpu during vdos
	assign int_n = !(pend_frm || pend_lin || (pend_dma && !vdos));

	always_ff @(posedge clk or posedge int_start_lin)
	begin
		if (int_start_lin)
			src_sel <= zint_pkg::SRC_FRM;
		else if (ack && (top_src != zint_pkg::SRC_NONE))
			src_sel <= top_src; // empty ack keeps the old vector
	end

	// upper nibble per source, then programmed bits, bit 0 always set
	always_comb
	begin
		case (src_sel)
			zint_pkg::SRC_FRM:
				im2vect = {4'hF, im2v_frm, 1'b1};
			zint_pkg::SRC_LIN:
				im2vect = {4'hE, im2v_lin, 1'b1};
			default:
				im2vect = {4'hD, im2v_dma, 1'b1};
		endcase
	end

endmodule

// ==== design/zint_pending.sv ====
`include "zint_settings.svh"

module zint_pending
(
	input  logic               clk,
	input  logic               int_start_lin,
	input  logic               frame_start,
	input  logic               line_start,
	input  logic               dma_done,
	input  logic               vdos,
	input  logic               ack,
	input  logic [2:0]         intmask,
	output logic               pend_frm,
	output logic               pend_lin,
	output logic               pend_dma,
	output zint_pkg::int_src_e top_src
);

	localparam int CNT_W = $clog2(`ZINT_FRM_LEN + 1);
	localparam logic [CNT_W-1:0] CNT_END = CNT_W'(`ZINT_FRM_LEN);

	logic [CNT_W-1:0] frm_cnt;
	logic             set_frm;
	logic             set_lin;
	logic             frm_expire;
	logic             ack_frm;
	logic             ack_lin;
	logic             ack_dma;

	// frame and line requests are dropped while vdos is active
	assign set_frm = frame_start && !vdos;
	assign set_lin = line_start && !vdos;

	// fixed priority, frame first
	always_comb
	begin
		if (pend_frm)
			top_src = zint_pkg::SRC_FRM;
		else if (pend_lin)
			top_src = zint_pkg::SRC_LIN;
		else if (pend_dma)
			top_src = zint_pkg::SRC_DMA;
		else
			top_src = zint_pkg::SRC_NONE;
	end

	// acknowledge only clears the winning flag
	assign ack_frm = ack && (top_src == zint_pkg::SRC_FRM);
	assign ack_lin = ack && (top_src == zint_pkg::SRC_LIN);
	assign ack_dma = ack && (top_src == zint_pkg::SRC_DMA);

	// counts clocks since the frame flag went up, parks at the end value
	always_ff @(posedge clk or posedge int_start_lin)
	begin
		if (int_start_lin)
			frm_cnt <= CNT_END;
		else if (intmask[0] && set_frm)
			frm_cnt <= 1; // restart on every accepted frame strobe
		else if (frm_cnt != CNT_END)
			frm_cnt <= frm_cnt + 1'b1;
	end

	assign frm_expire = pend_frm && (frm_cnt == CNT_END);

	always_ff @(posedge clk or posedge int_start_lin)
	begin
		if (int_start_lin)
			pend_frm <= 1'b0;
		else if (!intmask[0])
			pend_frm <= 1'b0;
		else if (set_frm)
			pend_frm <= 1'b1;
		else if (frm_expire || ack_frm)
			pend_frm <= 1'b0; // nobody took it in time
	end

	always_ff @(posedge clk or posedge int_start_lin)
	begin
		if (int_start_lin)
			pend_lin <= 1'b0;
		else if (!intmask[1])
			pend_lin <= 1'b0;
		else if (set_lin)
			pend_lin <= 1'b1;
		else if (ack_lin)
			pend_lin <= 1'b0;
	end

	// dma is kept through vdos, only its output is held back later
	always_ff @(posedge clk or posedge int_start_lin)
	begin
		if (int_start_lin)
			pend_dma <= 1'b0;
		else if (!intmask[2])
			pend_dma <= 1'b0;
		else if (dma_done)
			pend_dma <= 1'b1;
		else if (ack_dma)
			pend_dma <= 1'b0;
	end

endmodule

// ==== design/zint_bus_decode.sv ====
`include "zint_settings.svh"

module zint_bus_decode
(
	input  logic               clk,
	input  logic               int_start_lin,
	input  logic               intack,
	input  logic               io_wr,
	input  logic [7:0]         io_addr,
	input  logic [7:0]         io_data,
	output logic               ack,
	output logic [2:0]         intmask,
	output zint_pkg::vect_low_t im2v_frm,
	output zint_pkg::vect_low_t im2v_lin,
	output zint_pkg::vect_low_t im2v_dma
);

	logic intack_r; // intack seen at the previous edge
	logic wr_mask;
	logic wr_vfrm;
	logic wr_vlin;
	logic wr_vdma;

	// history starts high so an intack held through reset is no new edge
	always_ff @(posedge clk or posedge int_start_lin)
	begin
		if (int_start_lin)
			intack_r <= 1'b1;
		else
			intack_r <= intack;
	end

	assign ack = intack && !intack_r; // rising edge only

	// register selects
	assign wr_mask = io_wr && (io_addr == `ZINT_ADDR_MASK);
	assign wr_vfrm = io_wr && (io_addr == `ZINT_ADDR_VFRM);
	assign wr_vlin = io_wr && (io_addr == `ZINT_ADDR_VLIN);
	assign wr_vdma = io_wr && (io_addr == `ZINT_ADDR_VDMA);

	always_ff @(posedge clk or posedge int_start_lin)
	begin
		if (int_start_lin)
			intmask <= `ZINT_MASK_RST;
		else if (wr_mask)
			intmask <= io_data[2:0]; // bit 0 frame, 1 line, 2 dma
	end

	always_ff @(posedge clk or posedge int_start_lin)
	begin
		if (int_start_lin)
			im2v_frm <= '0;
		else if (wr_vfrm)
			im2v_frm <= io_data[2:0];
	end

	always_ff @(posedge clk or posedge int_start_lin)
	begin
		if (int_start_lin)
			im2v_lin <= '0;
		else if (wr_vlin)
			im2v_lin <= io_data[2:0];
	end

	always_ff @(posedge clk or posedge int_start_lin)
	begin
		if (int_start_lin)
			im2v_dma <= '0;
		else if (wr_vdma)
			im2v_dma <= io_data[2:0];
	end

endmodule

// ==== design/zint_pkg.sv ====
package zint_pkg;

	// interrupt sources, listed from highest to lowest priority
	typedef enum logic [1:0]
	{
		SRC_FRM  = 2'd0, // frame start
		SRC_LIN  = 2'd1, // line start
		SRC_DMA  = 2'd2, // dma done
		SRC_NONE = 2'd3  // nothing pending
	} int_src_e;

	// programmable bits 3..1 of a vector
	typedef logic [2:0] vect_low_t;

	// byte put on the data bus in the IM2 acknowledge cycle
	typedef logic [7:0] im2_vect_t;

endpackage

// ==== design/zint_settings.svh ====
`ifndef ZINT_SETTINGS_SVH
`define ZINT_SETTINGS_SVH

// I/O port map of the controller registers
`define ZINT_ADDR_MASK 8'h2A // enable bits, frame/line/dma
`define ZINT_ADDR_VFRM 8'h2B
`define ZINT_ADDR_VLIN 8'h2C
`define ZINT_ADDR_VDMA 8'h2D

// clocks a frame interrupt waits for its acknowledge
`define ZINT_FRM_LEN 32

// only the frame interrupt is on after reset
`define ZINT_MASK_RST 3'b001

`endif
